/* mem_pkg.sv */
// memory subsystem package with bus widths, sram geometry and the address map.
package mem_pkg;

	// cpu side data and address width.
	localparam int word_w = 32;

	localparam int sram_addr_w = 20; // address pins on each sram chip.

	// ram window starts at zero, this is the first byte address past it.
	localparam logic [word_w-1:0] ram_limit = 32'h0080_0000;

	// serial port registers.
	localparam logic [word_w-1:0] com_data_addr = 32'hBFD0_03F8;
	localparam logic [word_w-1:0] com_stat_addr = 32'hBFD0_03FC;

	localparam int com_stat_tx_bit = 0; // transmitter still shifting.
	localparam int com_stat_rx_bit = 1; // received byte waiting.

endpackage

/* uart_tx.sv */
// 8n1 serial transmitter with a clocks per bit divider.
module uart_tx #(
	parameter int clk_per_bit = 434
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic [7:0] byte_in,
	output logic txd,
	output logic tx_busy
);

	localparam int div_w = $clog2(clk_per_bit);
	localparam logic [div_w-1:0] div_last = div_w'(clk_per_bit - 1);

	logic [div_w-1:0] div_cnt;
	logic [3:0] bit_cnt;
	logic [9:0] shreg; // stop, data lsb first, start.

	assign txd = shreg[0]; // line idles high since the register fills with ones.

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_busy <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			shreg <= '1;
		end else if (!tx_busy) begin
			if (start) begin
				tx_busy <= 1'b1;
				shreg <= {1'b1, byte_in, 1'b0};
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (div_cnt == div_last) begin
			div_cnt <= '0;
			shreg <= {1'b1, shreg[9:1]};
			if (bit_cnt == 4'd9)
				tx_busy <= 1'b0; // stop bit has run its full length.
			else
				bit_cnt <= bit_cnt + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

/* uart_rx.sv */
// 8n1 serial receiver with input synchronizer, mid bit sampling and false start check.
module uart_rx #(
	parameter int clk_per_bit = 434
) (
	input  logic clk,
	input  logic rst,
	input  logic rxd,
	output logic [7:0] byte_out,
	output logic done
);

	localparam int div_w = $clog2(clk_per_bit);
	localparam logic [div_w-1:0] div_last = div_w'(clk_per_bit - 1);
	localparam logic [div_w-1:0] div_half = div_w'(clk_per_bit / 2 - 1);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [div_w-1:0] div_cnt;
	logic [2:0] bit_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rx_idle;
			div_cnt <= '0;
			bit_cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			div_cnt <= div_cnt + 1'b1;
			case (state)
				rx_idle: begin
					div_cnt <= '0;
					if (!rx_sync)
						state <= rx_start;
				end
				rx_start: begin
					if (div_cnt == div_half) begin
						div_cnt <= '0; // later samples now land mid bit.
						bit_cnt <= '0;
						state <= rx_sync ? rx_idle : rx_data; // glitch, not a start bit.
					end
				end
				rx_data: begin
					if (div_cnt == div_last) begin
						div_cnt <= '0;
						byte_out <= {rx_sync, byte_out[7:1]};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= rx_stop;
					end
				end
				rx_stop: begin
					if (div_cnt == div_last) begin
						done <= rx_sync; // framing error drops the byte.
						state <= rx_idle;
					end
				end
				default:
					state <= rx_idle;
			endcase
		end
	end

endmodule

/* com_ctrl.sv */
// serial port register block with data and status words around the transmitter and receiver.
module com_ctrl #(
	parameter int clk_per_bit = 434
) (
	input  logic clk,
	input  logic rst,
	input  logic com_data_write,
	input  logic com_stat_write,
	input  logic com_addr_stat,
	input  logic [7:0] data_in,
	input  logic com_rxd,
	output logic [mem_pkg::word_w-1:0] com_rdata,
	output logic tx_busy,
	output logic com_txd
);

	logic [7:0] rx_shift;
	logic rx_done;
	logic [7:0] rx_byte;
	logic rx_ready;
	logic [mem_pkg::word_w-1:0] stat_word;
	logic [mem_pkg::word_w-1:0] data_word;

	uart_tx #(
		.clk_per_bit(clk_per_bit)
	) uart_tx_i (
		.clk(clk),
		.rst(rst),
		.start(com_data_write),
		.byte_in(data_in),
		.txd(com_txd),
		.tx_busy(tx_busy)
	);

	uart_rx #(
		.clk_per_bit(clk_per_bit)
	) uart_rx_i (
		.clk(clk),
		.rst(rst),
		.rxd(com_rxd),
		.byte_out(rx_shift),
		.done(rx_done)
	);

	// a new byte wins over an acknowledge in the same cycle.
	always_ff @(posedge clk) begin
		if (rst)
			rx_ready <= 1'b0;
		else if (rx_done)
			rx_ready <= 1'b1;
		else if (com_stat_write)
			rx_ready <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rx_done)
			rx_byte <= rx_shift;
	end

	always_comb begin
		stat_word = '0;
		stat_word[mem_pkg::com_stat_tx_bit] = tx_busy;
		stat_word[mem_pkg::com_stat_rx_bit] = rx_ready;
	end

	assign data_word = {{(mem_pkg::word_w - 8){1'b0}}, rx_byte};

	assign com_rdata = com_addr_stat ? stat_word : data_word;

endmodule

/* phy_mem_ctrl.sv */
// sram write sequencer with chip select, strobes and data bus drive for base and ext chips.
module phy_mem_ctrl #(
	parameter int settle_cycles = 5
) (
	input  logic clk,
	input  logic rst,
	input  logic ram_write,
	input  logic [mem_pkg::word_w-1:0] addr,
	input  logic [mem_pkg::word_w-1:0] data_in,
	output logic [mem_pkg::word_w-1:0] ram_rdata,
	output logic ram_busy,
	output logic [mem_pkg::sram_addr_w-1:0] baseram_addr,
	inout  wire  [mem_pkg::word_w-1:0] baseram_data,
	output logic baseram_ce,
	output logic baseram_oe,
	output logic baseram_we,
	output logic [mem_pkg::sram_addr_w-1:0] extram_addr,
	inout  wire  [mem_pkg::word_w-1:0] extram_data,
	output logic extram_ce,
	output logic extram_oe,
	output logic extram_we
);

	localparam int cnt_w = (settle_cycles > 1) ? $clog2(settle_cycles) : 1;
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(settle_cycles - 1);

	// word address is one bit wider than a chip, the top bit picks ext.
	localparam int sel_bit = mem_pkg::sram_addr_w;

	typedef enum logic [1:0] {
		st_read   = 2'b00,
		st_setup  = 2'b01,
		st_strobe = 2'b11,
		st_settle = 2'b10
	} state_t;

	state_t state;
	logic [cnt_w-1:0] settle_cnt;
	logic [sel_bit:0] wr_addr;
	logic [mem_pkg::word_w-1:0] wr_data;
	logic [sel_bit:0] ram_word;
	logic writing;
	logic we_low;
	logic chip_sel;

	assign writing = (state == st_setup) || (state == st_strobe); // bus is ours, oe held high.
	assign we_low = (state == st_strobe);
	assign ram_busy = (state != st_read);

	// latched address while the write runs, live address for reads.
	assign ram_word = writing ? wr_addr : addr[sel_bit+2:2];
	assign chip_sel = ram_word[sel_bit]; // 1 selects the ext chip.

	assign baseram_addr = ram_word[sel_bit-1:0];
	assign extram_addr = ram_word[sel_bit-1:0];

	// all strobes are active low.
	assign baseram_ce = chip_sel;
	assign extram_ce = ~chip_sel;
	assign baseram_oe = chip_sel | writing;
	assign extram_oe = ~chip_sel | writing;
	assign baseram_we = chip_sel | ~we_low;
	assign extram_we = ~chip_sel | ~we_low;

	// a chip with oe high is not driving, so the write data can sit on its bus.
	assign baseram_data = baseram_oe ? wr_data : {mem_pkg::word_w{1'bz}};
	assign extram_data = extram_oe ? wr_data : {mem_pkg::word_w{1'bz}};

	assign ram_rdata = chip_sel ? extram_data : baseram_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_read;
			settle_cnt <= '0;
		end else begin
			case (state)
				st_read: begin
					if (ram_write)
						state <= st_setup; // address settles for a cycle before we.
				end
				st_setup:
					state <= st_strobe;
				st_strobe: begin
					settle_cnt <= '0;
					state <= st_settle;
				end
				st_settle: begin
					settle_cnt <= settle_cnt + 1'b1;
					if (settle_cnt == cnt_last)
						state <= st_read;
				end
				default:
					state <= st_read;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_read && ram_write) begin
			wr_addr <= addr[sel_bit+2:2];
			wr_data <= data_in;
		end
	end

endmodule

/* mem_bus_mux.sv */
// address decoder with write strobe routing, read data select and busy merge.
module mem_bus_mux (
	input  logic [mem_pkg::word_w-1:0] addr,
	input  logic is_write,
	input  logic [mem_pkg::word_w-1:0] ram_rdata,
	input  logic ram_busy,
	input  logic [mem_pkg::word_w-1:0] com_rdata,
	input  logic tx_busy,
	output logic ram_write,
	output logic com_data_write,
	output logic com_stat_write,
	output logic com_addr_stat,
	output logic [mem_pkg::word_w-1:0] data_out,
	output logic busy
);

	logic in_ram;
	logic is_data;
	logic is_stat;
	logic data_blocked;

	assign in_ram = (addr < mem_pkg::ram_limit);
	assign is_data = (addr == mem_pkg::com_data_addr);
	assign is_stat = (addr == mem_pkg::com_stat_addr);

	// transmitter still shifting the last byte.
	assign data_blocked = is_write & is_data & tx_busy;

	assign ram_write = is_write & in_ram;
	assign com_data_write = is_write & is_data & ~tx_busy; // dropped while blocked.
	assign com_stat_write = is_write & is_stat;
	assign com_addr_stat = is_stat;

	always_comb begin
		if (in_ram)
			data_out = ram_rdata;
		else if (is_data || is_stat)
			data_out = com_rdata;
		else
			data_out = '0; // unmapped space reads as zero.
	end

	// a ram write is busy from its own request cycle on.
	assign busy = ram_busy | ram_write | data_blocked;

endmodule

/* phy_mem_top.sv */
// top level joining the address decoder, sram controller and serial port to the board pins.
module phy_mem_top #(
	parameter int clk_per_bit = 434,
	parameter int settle_cycles = 5
) (
	input  logic clk,
	input  logic rst,
	input  logic is_write,
	input  logic [mem_pkg::word_w-1:0] addr,
	input  logic [mem_pkg::word_w-1:0] data_in,
	output logic [mem_pkg::word_w-1:0] data_out,
	output logic busy,
	input  logic com_rxd,
	output logic com_txd,
	output logic [mem_pkg::sram_addr_w-1:0] baseram_addr,
	inout  wire  [mem_pkg::word_w-1:0] baseram_data,
	output logic baseram_ce,
	output logic baseram_oe,
	output logic baseram_we,
	output logic [mem_pkg::sram_addr_w-1:0] extram_addr,
	inout  wire  [mem_pkg::word_w-1:0] extram_data,
	output logic extram_ce,
	output logic extram_oe,
	output logic extram_we
);

	logic ram_write;
	logic ram_busy;
	logic [mem_pkg::word_w-1:0] ram_rdata;
	logic com_data_write;
	logic com_stat_write;
	logic com_addr_stat;
	logic [mem_pkg::word_w-1:0] com_rdata;
	logic tx_busy;

	mem_bus_mux mem_bus_mux_i (
		.addr(addr),
		.is_write(is_write),
		.ram_rdata(ram_rdata),
		.ram_busy(ram_busy),
		.com_rdata(com_rdata),
		.tx_busy(tx_busy),
		.ram_write(ram_write),
		.com_data_write(com_data_write),
		.com_stat_write(com_stat_write),
		.com_addr_stat(com_addr_stat),
		.data_out(data_out),
		.busy(busy)
	);

	phy_mem_ctrl #(
		.settle_cycles(settle_cycles)
	) phy_mem_ctrl_i (
		.clk(clk),
		.rst(rst),
		.ram_write(ram_write),
		.addr(addr),
		.data_in(data_in),
		.ram_rdata(ram_rdata),
		.ram_busy(ram_busy),
		.baseram_addr(baseram_addr),
		.baseram_data(baseram_data),
		.baseram_ce(baseram_ce),
		.baseram_oe(baseram_oe),
		.baseram_we(baseram_we),
		.extram_addr(extram_addr),
		.extram_data(extram_data),
		.extram_ce(extram_ce),
		.extram_oe(extram_oe),
		.extram_we(extram_we)
	);

	// only the low byte goes out on the serial line.
	com_ctrl #(
		.clk_per_bit(clk_per_bit)
	) com_ctrl_i (
		.clk(clk),
		.rst(rst),
		.com_data_write(com_data_write),
		.com_stat_write(com_stat_write),
		.com_addr_stat(com_addr_stat),
		.data_in(data_in[7:0]),
		.com_rxd(com_rxd),
		.com_rdata(com_rdata),
		.tx_busy(tx_busy),
		.com_txd(com_txd)
	);

endmodule

/* sram_model.sv */
// behavioral asynchronous sram with active low strobes, a tristate data bus and an address fill.
module sram_model #(
	parameter int addr_w = 20,
	parameter logic [11:0] fill_tag = 12'h000
) (
	input  logic [addr_w-1:0] addr,
	inout  wire  [31:0] data,
	input  logic ce,
	input  logic oe,
	input  logic we
);

	logic [31:0] mem [0:2**addr_w-1];

	// every word starts as its chip tag over its own address.
	initial begin
		for (int i = 0; i < 2**addr_w; i++)
			mem[i] = {fill_tag, 20'(i)};
	end

	assign data = (!ce && !oe) ? mem[addr] : {32{1'bz}}; // drives only while read enabled.

	// the controller holds address and data steady across the whole we low phase.
	always @(negedge we) begin
		if (!ce)
			mem[addr] <= data;
	end

endmodule

/* phy_mem_tb.sv */
// testbench for the memory subsystem with two sram models, serial loopback and a stimulus table.
module phy_mem_tb;

	localparam int clk_per_bit = 8;
	localparam int settle_cycles = 5;
	localparam int wait_limit = 40 * clk_per_bit;
	localparam int op_write = 0;
	localparam int op_held = 1; // data write that must stall behind a busy transmitter.
	localparam int op_read = 2;
	localparam int op_rx_wait = 3;
	localparam int op_tx_wait = 4;
	localparam logic [11:0] base_tag = 12'hBA5;
	localparam logic [11:0] ext_tag = 12'hE47;

	logic clk;
	logic rst;
	logic is_write;
	logic [mem_pkg::word_w-1:0] addr;
	logic [mem_pkg::word_w-1:0] data_in;
	logic [mem_pkg::word_w-1:0] data_out;
	logic busy;
	wire com_rxd;
	logic com_txd;
	logic [mem_pkg::sram_addr_w-1:0] baseram_addr;
	wire [mem_pkg::word_w-1:0] baseram_data;
	logic baseram_ce;
	logic baseram_oe;
	logic baseram_we;
	logic [mem_pkg::sram_addr_w-1:0] extram_addr;
	wire [mem_pkg::word_w-1:0] extram_data;
	logic extram_ce;
	logic extram_oe;
	logic extram_we;

	int mismatches;
	int timeouts;
	int checks;
	logic [15:0] lfsr;
	logic [31:0] ram_sb [int]; // expected ram words by word address.

	string row_name[$];
	int row_op[$];
	logic [31:0] row_addr[$];
	logic [31:0] row_data[$];
	logic [31:0] row_exp[$];
	bit row_rnd[$];

	assign com_rxd = com_txd; // serial loopback.

	phy_mem_top #(
		.clk_per_bit(clk_per_bit),
		.settle_cycles(settle_cycles)
	) phy_mem_top_i (.*);

	sram_model #(.fill_tag(base_tag)) base_sram_i (
		.addr(baseram_addr),
		.data(baseram_data),
		.ce(baseram_ce),
		.oe(baseram_oe),
		.we(baseram_we)
	);

	sram_model #(.fill_tag(ext_tag)) ext_sram_i (
		.addr(extram_addr),
		.data(extram_data),
		.ce(extram_ce),
		.oe(extram_oe),
		.we(extram_we)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout: %s did not happen within %0d cycles", what, wait_limit);
	endtask

	// taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_next(lfsr);
			w = {w[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] ram_expect(input logic [31:0] a);
		if (ram_sb.exists(int'(a[22:2])))
			return ram_sb[int'(a[22:2])];
		return {a[22] ? ext_tag : base_tag, a[21:2]}; // untouched word keeps its fill.
	endfunction

	task automatic add_row(input string name, input int op, input logic [31:0] a,
			input logic [31:0] d, input logic [31:0] e, input bit rnd);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(a);
		row_data.push_back(d);
		row_exp.push_back(e);
		row_rnd.push_back(rnd);
	endtask

	// held counts busy cycles after a ram strobe, or stall cycles of a non ram write.
	task automatic write_cycle(input string name, input logic [31:0] a, input logic [31:0] d,
			output int held);
		held = 0;
		@(negedge clk);
		addr = a;
		data_in = d;
		is_write = 1'b1;
		#25;
		if (a < mem_pkg::ram_limit) begin
			check_value({name, " request busy"}, 32'd1, 32'(busy));
			@(negedge clk);
			is_write = 1'b0;
			#25;
		end
		while (busy && held < wait_limit) begin
			held++;
			@(negedge clk);
			#25;
		end
		if (busy)
			report_timeout({name, " busy release"});
		if (is_write) begin
			@(negedge clk);
			is_write = 1'b0;
			#25;
			check_value({name, " busy after strobe"}, 32'd0, 32'(busy));
		end
	endtask

	task automatic read_check(input string name, input logic [31:0] a, input logic [31:0] expected);
		@(negedge clk);
		addr = a;
		is_write = 1'b0;
		#25;
		check_value(name, expected, data_out);
	endtask

	task automatic wait_status(input string name, input int pos, input logic level);
		int n;
		n = 0;
		@(negedge clk);
		addr = mem_pkg::com_stat_addr;
		#25;
		while (data_out[pos] !== level && n < wait_limit) begin
			n++;
			@(negedge clk);
			#25;
		end
		if (data_out[pos] !== level)
			report_timeout(name);
	endtask

	task automatic build_table();
		add_row("base word 0 write", op_write, 32'h0000_0000, 0, 0, 1);
		add_row("ext word 0 write", op_write, 32'h0040_0000, 0, 0, 1);
		add_row("base top write", op_write, 32'h003F_FFFC, 0, 0, 1);
		add_row("ext top write", op_write, 32'h007F_FFFC, 0, 0, 1);
		add_row("ext mid write", op_write, 32'h0040_0100, 0, 0, 1);
		add_row("base mid write", op_write, 32'h0000_0100, 0, 0, 1);
		add_row("base word 0 read", op_read, 32'h0000_0000, 0, 0, 0);
		add_row("ext word 0 read", op_read, 32'h0040_0000, 0, 0, 0);
		add_row("base top read", op_read, 32'h003F_FFFC, 0, 0, 0);
		add_row("ext top read", op_read, 32'h007F_FFFC, 0, 0, 0);
		add_row("ext mid read", op_read, 32'h0040_0100, 0, 0, 0);
		add_row("base mid read", op_read, 32'h0000_0100, 0, 0, 0);
		add_row("base only write", op_write, 32'h0000_0200, 0, 0, 1);
		add_row("ext untouched read", op_read, 32'h0040_0200, 0, 0, 0);
		add_row("base only read", op_read, 32'h0000_0200, 0, 0, 0);
		add_row("unmapped write", op_write, 32'h1000_0000, 32'hDEAD_BEEF, 0, 0);
		add_row("unmapped read", op_read, 32'h1000_0000, 0, 32'h0, 0);
		add_row("ram limit write", op_write, mem_pkg::ram_limit, 32'h1234_5678, 0, 0);
		add_row("ram limit read", op_read, mem_pkg::ram_limit, 0, 32'h0, 0);
		add_row("alias word 0 read", op_read, 32'h0000_0000, 0, 0, 0);
		add_row("tx a5 write", op_write, mem_pkg::com_data_addr, 32'hFFFF_FFA5, 0, 0);
		add_row("status tx busy", op_read, mem_pkg::com_stat_addr, 0, 32'h1, 0);
		add_row("rx a5 wait", op_rx_wait, 0, 0, 0, 0);
		add_row("tx a5 idle wait", op_tx_wait, 0, 0, 0, 0);
		add_row("rx a5 data", op_read, mem_pkg::com_data_addr, 0, 32'hA5, 0);
		add_row("status rx ready", op_read, mem_pkg::com_stat_addr, 0, 32'h2, 0);
		add_row("rx a5 ack", op_write, mem_pkg::com_stat_addr, 0, 0, 0);
		add_row("status cleared", op_read, mem_pkg::com_stat_addr, 0, 32'h0, 0);
		add_row("tx 3c write", op_write, mem_pkg::com_data_addr, 32'h3C, 0, 0);
		add_row("tx 96 stalled write", op_held, mem_pkg::com_data_addr, 32'h96, 0, 0);
		add_row("rx 3c wait", op_rx_wait, 0, 0, 0, 0);
		add_row("rx 3c ack", op_write, mem_pkg::com_stat_addr, 0, 0, 0);
		add_row("rx 96 wait", op_rx_wait, 0, 0, 0, 0);
		add_row("rx 96 data", op_read, mem_pkg::com_data_addr, 0, 32'h96, 0);
		add_row("tx 96 idle wait", op_tx_wait, 0, 0, 0, 0);
		add_row("rx 96 ack", op_write, mem_pkg::com_stat_addr, 0, 0, 0);
		add_row("status final", op_read, mem_pkg::com_stat_addr, 0, 32'h0, 0);
	endtask

	initial begin
		int held;
		logic [31:0] a;
		logic [31:0] d;
		rst = 1'b1;
		is_write = 1'b0;
		addr = '0;
		data_in = '0;
		mismatches = 0;
		timeouts = 0;
		checks = 0;
		lfsr = 16'd82;
		build_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#25;
		check_value("idle busy", 32'd0, 32'(busy));
		check_value("idle base we", 32'd1, 32'(baseram_we));
		check_value("idle ext we", 32'd1, 32'(extram_we));
		// address zero selects the base chip, strobes are active low.
		check_value("idle base ce", 32'd0, 32'(baseram_ce));
		check_value("idle ext ce", 32'd1, 32'(extram_ce));
		check_value("idle base oe", 32'd0, 32'(baseram_oe));
		check_value("idle txd", 32'd1, 32'(com_txd));
		for (int i = 0; i < row_name.size(); i++) begin
			a = row_addr[i];
			d = row_data[i];
			case (row_op[i])
				op_write, op_held: begin
					if (row_rnd[i])
						random_word(d);
					write_cycle(row_name[i], a, d, held);
					if (a < mem_pkg::ram_limit) begin
						ram_sb[int'(a[22:2])] = d;
						check_value({row_name[i], " busy cycles"}, 32'(2 + settle_cycles), 32'(held));
					end else begin
						check_value({row_name[i], " stall"}, 32'(row_op[i] == op_held), 32'(held > 0));
					end
				end
				op_read: begin
					if (a < mem_pkg::ram_limit)
						read_check(row_name[i], a, ram_expect(a));
					else
						read_check(row_name[i], a, row_exp[i]);
				end
				op_rx_wait:
					wait_status(row_name[i], mem_pkg::com_stat_rx_bit, 1'b1);
				op_tx_wait:
					wait_status(row_name[i], mem_pkg::com_stat_tx_bit, 1'b0);
				default:
					report_timeout({row_name[i], " with an unknown operation"});
			endcase
		end
		$display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* project.f */
mem_pkg.sv
uart_tx.sv
uart_rx.sv
com_ctrl.sv
phy_mem_ctrl.sv
mem_bus_mux.sv
phy_mem_top.sv
sram_model.sv
phy_mem_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module phy_mem_tb -f project.f -o phy_mem_sim
./obj_dir/phy_mem_sim > sim.log
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation did not pass"
	exit 1
fi
